/* ctrl_link_pkg.sv */
// control link package with frame constants, widths and the checksum rule
package ctrl_link_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int BYTE_W = 8;

	// default width of the bit-period counter and of tbit_period
	localparam int PERIOD_W = 20;

	// ------------------------------
	// frame layout
	// ------------------------------
	// sync, address, data, checksum
	localparam int FRAME_BYTES = 4;

	localparam logic [BYTE_W-1:0] SYNC_BYTE = 8'hA5;

	// checksum covers the sync byte too
	function automatic logic [BYTE_W-1:0] frame_csum(
		input logic [BYTE_W-1:0] addr,
		input logic [BYTE_W-1:0] data
	);
		return SYNC_BYTE ^ addr ^ data;
	endfunction

endpackage

/* sim_ctrl_phy.sv */
// bit-level transmitter sending start, 8 data bits MSB first and two stop bits
`timescale 1ns/1ps

module sim_ctrl_phy #(
	parameter int period_w = ctrl_link_pkg::PERIOD_W
) (
	input  logic                             fire_tx,
	input  logic [ctrl_link_pkg::BYTE_W-1:0] data_tx,
	input  logic [period_w-1:0]              tbit_period,
	output logic                             done_tx,
	output logic                             tx_ctrl,
	input  logic                             clk_sys,
	input  logic                             rst_n
);

	// states in line order so a bit step is a plain increment
	typedef enum logic [3:0] {
		S_IDLE  = 4'h0,
		S_START = 4'h1,
		S_S7    = 4'h2,
		S_S6    = 4'h3,
		S_S5    = 4'h4,
		S_S4    = 4'h5,
		S_S3    = 4'h6,
		S_S2    = 4'h7,
		S_S1    = 4'h8,
		S_S0    = 4'h9,
		S_STOP  = 4'ha,
		S_STOP2 = 4'hb,
		S_DONE  = 4'hc
	} tx_state_t;

	tx_state_t st_tx_phy;
	logic [ctrl_link_pkg::BYTE_W-1:0] data_q;
	logic [period_w-1:0] cnt_cycle;
	logic send_bit;
	logic finish_bit;

	// byte held for the whole character
	always_ff @(posedge clk_sys) begin
		if (fire_tx && st_tx_phy == S_IDLE)
			data_q <= data_tx;
	end

	// ------------------------------
	// main FSM
	// ------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_tx_phy <= S_IDLE;
		end else begin
			case (st_tx_phy)
				S_IDLE: if (fire_tx) st_tx_phy <= S_START;
				S_STOP2: if (finish_bit) st_tx_phy <= S_DONE;
				S_DONE: st_tx_phy <= S_IDLE;
				default: if (finish_bit) st_tx_phy <= tx_state_t'(st_tx_phy + 4'd1);
			endcase
		end
	end

	assign send_bit = (st_tx_phy != S_IDLE) && (st_tx_phy != S_DONE);

	// ------------------------------
	// bit period counter
	// ------------------------------
	assign finish_bit = send_bit && (cnt_cycle == tbit_period - period_w'(1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_cycle <= '0;
		else if (send_bit && !finish_bit)
			cnt_cycle <= cnt_cycle + period_w'(1);
		else
			cnt_cycle <= '0;
	end

	// ------------------------------
	// outputs
	// ------------------------------
	assign done_tx = (st_tx_phy == S_DONE);

	// line idles high, stop bits high as well
	always_comb begin
		case (st_tx_phy)
			S_START: tx_ctrl = 1'b0;
			S_S7:    tx_ctrl = data_q[7];
			S_S6:    tx_ctrl = data_q[6];
			S_S5:    tx_ctrl = data_q[5];
			S_S4:    tx_ctrl = data_q[4];
			S_S3:    tx_ctrl = data_q[3];
			S_S2:    tx_ctrl = data_q[2];
			S_S1:    tx_ctrl = data_q[1];
			S_S0:    tx_ctrl = data_q[0];
			default: tx_ctrl = 1'b1;
		endcase
	end

endmodule

/* sim_ctrl_rx_phy.sv */
// bit-level receiver sampling each bit at its centre and checking both stop bits
`timescale 1ns/1ps

module sim_ctrl_rx_phy #(
	parameter int period_w = ctrl_link_pkg::PERIOD_W
) (
	input  logic                             rx_ctrl,
	input  logic [period_w-1:0]              tbit_period,
	output logic                             byte_valid,
	output logic [ctrl_link_pkg::BYTE_W-1:0] byte_data,
	output logic                             stop_err,
	input  logic                             clk_sys,
	input  logic                             rst_n
);

	typedef enum logic [2:0] {
		R_IDLE,
		R_START,
		R_DATA,
		R_STOP,
		R_STOP2
	} rx_state_t;

	rx_state_t st_rx_phy;
	logic rx_s1;
	logic rx_s2;
	logic rx_s3;
	logic fall;
	logic [period_w-1:0] cnt_cycle;
	logic [period_w-1:0] limit;
	logic bit_end;
	logic [2:0] bit_cnt;
	logic stop1_ok;
	logic [ctrl_link_pkg::BYTE_W-1:0] shift_q;

	// ------------------------------
	// line synchronizer
	// ------------------------------
	// reset to the idle level so no false edge after reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_s3 <= 1'b1;
		end else begin
			rx_s1 <= rx_ctrl;
			rx_s2 <= rx_s1;
			rx_s3 <= rx_s2;
		end
	end

	assign fall = rx_s3 & ~rx_s2;

	// half a period to reach mid start bit, then full periods
	assign limit = (st_rx_phy == R_START) ? (tbit_period >> 1) - period_w'(1)
	                                      : tbit_period - period_w'(1);
	assign bit_end = (st_rx_phy != R_IDLE) && (cnt_cycle == limit);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_cycle <= '0;
		else if (st_rx_phy == R_IDLE || bit_end)
			cnt_cycle <= '0;
		else
			cnt_cycle <= cnt_cycle + period_w'(1);
	end

	// ------------------------------
	// receive FSM
	// ------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_rx_phy  <= R_IDLE;
			bit_cnt    <= '0;
			stop1_ok   <= 1'b0;
			byte_valid <= 1'b0;
			stop_err   <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			stop_err   <= 1'b0;
			case (st_rx_phy)
				R_IDLE: if (fall) st_rx_phy <= R_START;
				R_START: begin
					bit_cnt <= '0;
					// line back high at mid start bit is a false start
					if (bit_end)
						st_rx_phy <= rx_s2 ? R_IDLE : R_DATA;
				end
				R_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							st_rx_phy <= R_STOP;
					end
				end
				R_STOP: begin
					if (bit_end) begin
						stop1_ok  <= rx_s2;
						st_rx_phy <= R_STOP2;
					end
				end
				R_STOP2: begin
					if (bit_end) begin
						byte_valid <= stop1_ok & rx_s2;
						stop_err   <= ~(stop1_ok & rx_s2);
						st_rx_phy  <= R_IDLE;
					end
				end
				default: st_rx_phy <= R_IDLE;
			endcase
		end
	end

	// MSB arrives first and ends up on top
	always_ff @(posedge clk_sys) begin
		if (st_rx_phy == R_DATA && bit_end)
			shift_q <= {shift_q[ctrl_link_pkg::BYTE_W-2:0], rx_s2};
	end

	assign byte_data = shift_q;

endmodule

/* ctrl_frame_tx.sv */
// frame sender feeding sync, address, data and checksum bytes into the transmitter
`timescale 1ns/1ps

module ctrl_frame_tx (
	input  logic                             send,
	input  logic [ctrl_link_pkg::BYTE_W-1:0] addr,
	input  logic [ctrl_link_pkg::BYTE_W-1:0] data,
	input  logic                             done_tx,
	output logic                             fire_tx,
	output logic [ctrl_link_pkg::BYTE_W-1:0] data_tx,
	output logic                             tx_busy,
	output logic                             frame_done,
	input  logic                             clk_sys,
	input  logic                             rst_n
);

	localparam int IDX_W = $clog2(ctrl_link_pkg::FRAME_BYTES);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(ctrl_link_pkg::FRAME_BYTES - 1);

	logic busy_q;
	logic [IDX_W-1:0] idx;
	logic [ctrl_link_pkg::BYTE_W-1:0] addr_q;
	logic [ctrl_link_pkg::BYTE_W-1:0] data_q;
	logic [ctrl_link_pkg::BYTE_W-1:0] csum_q;
	logic accept;
	logic last_done;

	assign accept    = send & ~tx_busy;
	assign last_done = busy_q & done_tx & (idx == LAST_IDX);

	// busy drops in the frame_done cycle
	assign frame_done = last_done;
	assign tx_busy    = busy_q & ~last_done;

	// ------------------------------
	// byte sequencer
	// ------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy_q  <= 1'b0;
			idx     <= '0;
			fire_tx <= 1'b0;
		end else if (accept) begin
			busy_q  <= 1'b1;
			idx     <= '0;
			fire_tx <= 1'b1;
		end else if (busy_q && done_tx) begin
			if (idx == LAST_IDX) begin
				busy_q  <= 1'b0;
				fire_tx <= 1'b0;
			end else begin
				idx     <= idx + IDX_W'(1);
				fire_tx <= 1'b1;
			end
		end else begin
			fire_tx <= 1'b0;
		end
	end

	// frame contents captured once per frame
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			addr_q <= addr;
			data_q <= data;
			csum_q <= ctrl_link_pkg::frame_csum(addr, data);
		end
	end

	always_comb begin
		case (idx)
			IDX_W'(0): data_tx = ctrl_link_pkg::SYNC_BYTE;
			IDX_W'(1): data_tx = addr_q;
			IDX_W'(2): data_tx = data_q;
			default:   data_tx = csum_q;
		endcase
	end

endmodule

/* ctrl_frame_rx.sv */
// frame parser hunting for sync, collecting address and data, and checking the checksum
`timescale 1ns/1ps

module ctrl_frame_rx (
	input  logic                             byte_valid,
	input  logic [ctrl_link_pkg::BYTE_W-1:0] byte_data,
	input  logic                             stop_err,
	output logic                             frame_valid,
	output logic                             frame_err,
	output logic [ctrl_link_pkg::BYTE_W-1:0] rx_addr,
	output logic [ctrl_link_pkg::BYTE_W-1:0] rx_data,
	input  logic                             clk_sys,
	input  logic                             rst_n
);

	localparam int IDX_W = $clog2(ctrl_link_pkg::FRAME_BYTES);
	localparam logic [IDX_W-1:0] IDX_SYNC = IDX_W'(0);
	localparam logic [IDX_W-1:0] IDX_ADDR = IDX_W'(1);
	localparam logic [IDX_W-1:0] IDX_DATA = IDX_W'(2);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(ctrl_link_pkg::FRAME_BYTES - 1);

	// index of the byte expected next, zero while hunting
	logic [IDX_W-1:0] idx;
	logic [ctrl_link_pkg::BYTE_W-1:0] addr_q;
	logic [ctrl_link_pkg::BYTE_W-1:0] data_q;
	logic csum_ok;

	assign csum_ok = (byte_data == ctrl_link_pkg::frame_csum(addr_q, data_q));

	// ------------------------------
	// parser state
	// ------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			idx         <= IDX_SYNC;
			frame_valid <= 1'b0;
			frame_err   <= 1'b0;
			rx_addr     <= '0;
			rx_data     <= '0;
		end else begin
			frame_valid <= 1'b0;
			frame_err   <= 1'b0;
			if (stop_err) begin
				// broken character kills the frame in progress
				frame_err <= 1'b1;
				idx       <= IDX_SYNC;
			end else if (byte_valid) begin
				if (idx == IDX_SYNC) begin
					// anything but sync is dropped
					if (byte_data == ctrl_link_pkg::SYNC_BYTE)
						idx <= IDX_ADDR;
				end else if (idx == LAST_IDX) begin
					idx <= IDX_SYNC;
					if (csum_ok) begin
						frame_valid <= 1'b1;
						rx_addr     <= addr_q;
						rx_data     <= data_q;
					end else begin
						frame_err <= 1'b1;
					end
				end else begin
					idx <= idx + IDX_W'(1);
				end
			end
		end
	end

	// ------------------------------
	// frame payload
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (byte_valid && idx == IDX_ADDR)
			addr_q <= byte_data;
		if (byte_valid && idx == IDX_DATA)
			data_q <= byte_data;
	end

endmodule

/* ctrl_link_top.sv */
// control link top with the frame sender and transmitter, receiver and frame parser
`timescale 1ns/1ps

module ctrl_link_top #(
	parameter int period_w = ctrl_link_pkg::PERIOD_W
) (
	input  logic                             send,
	input  logic [ctrl_link_pkg::BYTE_W-1:0] addr,
	input  logic [ctrl_link_pkg::BYTE_W-1:0] data,
	output logic                             tx_busy,
	output logic                             frame_done,
	output logic                             frame_valid,
	output logic [ctrl_link_pkg::BYTE_W-1:0] rx_addr,
	output logic [ctrl_link_pkg::BYTE_W-1:0] rx_data,
	output logic                             frame_err,
	output logic                             tx_line,
	input  logic                             rx_line,
	input  logic [period_w-1:0]              tbit_period,
	input  logic                             clk_sys,
	input  logic                             rst_n
);

	logic fire_tx;
	logic [ctrl_link_pkg::BYTE_W-1:0] data_tx;
	logic done_tx;
	logic byte_valid;
	logic [ctrl_link_pkg::BYTE_W-1:0] byte_data;
	logic stop_err;

	// ------------------------------
	// transmit path
	// ------------------------------
	ctrl_frame_tx u_frame_tx (
		.send       (send),
		.addr       (addr),
		.data       (data),
		.done_tx    (done_tx),
		.fire_tx    (fire_tx),
		.data_tx    (data_tx),
		.tx_busy    (tx_busy),
		.frame_done (frame_done),
		.clk_sys    (clk_sys),
		.rst_n      (rst_n)
	);

	sim_ctrl_phy #(.period_w(period_w)) u_tx_phy (
		.fire_tx     (fire_tx),
		.data_tx     (data_tx),
		.tbit_period (tbit_period),
		.done_tx     (done_tx),
		.tx_ctrl     (tx_line),
		.clk_sys     (clk_sys),
		.rst_n       (rst_n)
	);

	// ------------------------------
	// receive path
	// ------------------------------
	sim_ctrl_rx_phy #(.period_w(period_w)) u_rx_phy (
		.rx_ctrl     (rx_line),
		.tbit_period (tbit_period),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.stop_err    (stop_err),
		.clk_sys     (clk_sys),
		.rst_n       (rst_n)
	);

	ctrl_frame_rx u_frame_rx (
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.stop_err    (stop_err),
		.frame_valid (frame_valid),
		.frame_err   (frame_err),
		.rx_addr     (rx_addr),
		.rx_data     (rx_data),
		.clk_sys     (clk_sys),
		.rst_n       (rst_n)
	);

endmodule

/* ctrl_link_asserts.sv */
// protocol assertions for the control link top, attached by bind
`timescale 1ns/1ps

module ctrl_link_asserts (
	input logic clk_sys,
	input logic rst_n,
	input logic fire_tx,
	input logic done_tx,
	input logic tx_busy,
	input logic tx_line,
	input logic frame_valid,
	input logic frame_err
);

	// character in flight from fire to done
	logic phy_active;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			phy_active <= 1'b0;
		else if (fire_tx)
			phy_active <= 1'b1;
		else if (done_tx)
			phy_active <= 1'b0;
	end

	fire_only_idle: assert property (
		@(posedge clk_sys) disable iff (!rst_n) fire_tx |-> !phy_active
	) else $error("fire_tx while the transmitter is busy");

	valid_err_apart: assert property (
		@(posedge clk_sys) disable iff (!rst_n) !(frame_valid && frame_err)
	) else $error("frame_valid and frame_err high together");

	// line idles high between frames
	idle_line_high: assert property (
		@(posedge clk_sys) disable iff (!rst_n) !tx_busy |-> tx_line
	) else $error("tx_line low while tx_busy is low");

endmodule

bind ctrl_link_top ctrl_link_asserts u_link_asserts (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.fire_tx     (fire_tx),
	.done_tx     (done_tx),
	.tx_busy     (tx_busy),
	.tx_line     (tx_line),
	.frame_valid (frame_valid),
	.frame_err   (frame_err)
);

/* tb_ctrl_link.sv */
// testbench for the control link driving a frame table through a looped-back line
`timescale 1ns/1ps

module tb_ctrl_link;

	localparam int PER_W = 16;
	localparam int ROWS = 8;
	localparam int INJ_NONE = 0;
	localparam int INJ_CSUM = 1;
	localparam int INJ_STOP = 2;

	typedef struct {
		int         tbit;
		logic [7:0] addr;
		logic [7:0] data;
		int         mode;
		bit         extra;
		bit         ok;
	} row_t;

	logic clk_sys;
	logic rst_n;
	logic send;
	logic [7:0] addr;
	logic [7:0] data;
	logic [PER_W-1:0] tbit_period;
	logic tx_busy;
	logic frame_done;
	logic frame_valid;
	logic frame_err;
	logic [7:0] rx_addr;
	logic [7:0] rx_data;
	logic tx_line;
	logic rx_line;
	logic inj_on;
	logic [7:0] exp_addr;
	logic [7:0] exp_data;

	row_t rows [ROWS];
	int seed;
	int cyc = 0;
	int cyc_limit = 0;
	int valid_cnt = 0;
	int err_cnt = 0;

	// loopback, inverted while an injection window is open
	assign rx_line = tx_line ^ inj_on;

	ctrl_link_top #(.period_w(PER_W)) UUT (
		.send        (send),
		.addr        (addr),
		.data        (data),
		.tx_busy     (tx_busy),
		.frame_done  (frame_done),
		.frame_valid (frame_valid),
		.rx_addr     (rx_addr),
		.rx_data     (rx_data),
		.frame_err   (frame_err),
		.tx_line     (tx_line),
		.rx_line     (rx_line),
		.tbit_period (tbit_period),
		.clk_sys     (clk_sys),
		.rst_n       (rst_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// result pulses counted mid-cycle
	always @(negedge clk_sys) begin
		if (frame_valid)
			valid_cnt++;
		if (frame_err)
			err_cnt++;
	end

	always @(posedge clk_sys) begin
		cyc++;
		if (cyc > cyc_limit) begin
			$display("timeout: run went past %0d cycles", cyc_limit);
			end_with_failure();
		end
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic end_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			end_with_failure();
		end
	endtask

	function automatic logic [7:0] xor_sum(input logic [7:0] a, input logic [7:0] d);
		return ctrl_link_pkg::SYNC_BYTE ^ a ^ d;
	endfunction

	task automatic load_table();
		seed = 6;
		rows[0] = '{4, 8'h12, 8'h34, INJ_NONE, 1'b0, 1'b1};
		rows[1] = '{7, 8'h00, 8'h00, INJ_NONE, 1'b0, 1'b1};
		rows[2] = '{16, 8'h3c, 8'hc3, INJ_CSUM, 1'b0, 1'b0};
		rows[3] = '{10, 8'h00, 8'h00, INJ_NONE, 1'b0, 1'b1};
		rows[4] = '{9, 8'h5a, 8'h0f, INJ_STOP, 1'b0, 1'b0};
		rows[5] = '{9, 8'h00, 8'h00, INJ_NONE, 1'b0, 1'b1};
		rows[6] = '{6, 8'h81, 8'h7e, INJ_NONE, 1'b1, 1'b1};
		rows[7] = '{5, 8'h00, 8'h00, INJ_NONE, 1'b0, 1'b1};
		// odd rows carry a random payload
		for (int i = 1; i < ROWS; i += 2) begin
			rows[i].addr = 8'($random(seed));
			rows[i].data = 8'($random(seed));
		end
	endtask

	function automatic int run_budget();
		int total;
		total = 96;
		for (int i = 0; i < ROWS; i++)
			total += 4 * (11 * rows[i].tbit + 2) + 6 * rows[i].tbit + 64;
		return total;
	endfunction

	// ------------------------------
	// one frame from the table
	// ------------------------------
	task automatic run_row(input int i);
		row_t r;
		int n_exp;
		int cnt;
		int lo;
		int hi;
		int v0;
		int e0;
		int wait_cnt;
		bit done_seen;
		r = rows[i];
		n_exp = 4 * (11 * r.tbit + 2) - 1;
		// window in cycles after the accepting edge, byte b starts at 1 + b*(11T+2)
		lo = 0;
		if (r.mode == INJ_CSUM)
			lo = 1 + 3 * (11 * r.tbit + 2) + 8 * r.tbit;
		else if (r.mode == INJ_STOP)
			lo = 1 + 2 * (11 * r.tbit + 2) + 10 * r.tbit;
		hi = (r.mode == INJ_NONE) ? 0 : lo + r.tbit;
		// checksum byte must not pass for sync once the parser is hunting again
		if (r.mode == INJ_STOP && xor_sum(r.addr, r.data) == ctrl_link_pkg::SYNC_BYTE) begin
			$display("row %0d: checksum equals the sync byte, row is unusable", i);
			end_with_failure();
		end
		@(posedge clk_sys);
		#1;
		tbit_period = PER_W'(r.tbit);
		send = 1'b1;
		addr = r.addr;
		data = r.data;
		v0 = valid_cnt;
		e0 = err_cnt;
		check_val("tx_busy", 32'(tx_busy), 32'h0);
		@(posedge clk_sys);
		#1;
		send = 1'b0;
		cnt = 0;
		done_seen = 1'b0;
		while (!done_seen) begin
			@(negedge clk_sys);
			if (frame_done) begin
				done_seen = 1'b1;
				check_val("frame_done latency", cnt, n_exp);
				check_val("tx_busy", 32'(tx_busy), 32'h0);
			end else begin
				check_val("tx_busy", 32'(tx_busy), 32'h1);
				if (cnt > n_exp) begin
					$display("row %0d: frame_done did not arrive after %0d cycles", i, cnt);
					end_with_failure();
				end
				@(posedge clk_sys);
				#1;
				cnt++;
				inj_on = (cnt >= lo) && (cnt < hi);
				// second send with other values while busy
				if (r.extra && cnt == 3 * r.tbit) begin
					send = 1'b1;
					addr = ~r.addr;
					data = ~r.data;
				end else begin
					send = 1'b0;
				end
			end
		end
		inj_on = 1'b0;
		wait_cnt = 0;
		while (valid_cnt == v0 && err_cnt == e0) begin
			if (wait_cnt > 3 * r.tbit + 20) begin
				$display("row %0d: receiver gave no frame result", i);
				end_with_failure();
			end
			@(negedge clk_sys);
			wait_cnt++;
		end
		// quiet time so a second result would be seen
		repeat (2 * r.tbit + 8) @(negedge clk_sys);
		check_val("frame_valid count", valid_cnt - v0, r.ok ? 1 : 0);
		check_val("frame_err count", err_cnt - e0, r.ok ? 0 : 1);
		if (r.ok) begin
			exp_addr = r.addr;
			exp_data = r.data;
		end
		check_val("rx_addr", 32'(rx_addr), 32'(exp_addr));
		check_val("rx_data", 32'(rx_data), 32'(exp_data));
	endtask

	initial begin
		rst_n = 1'b0;
		send = 1'b0;
		addr = '0;
		data = '0;
		tbit_period = PER_W'(4);
		inj_on = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		load_table();
		cyc_limit = run_budget();
		repeat (16) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		@(negedge clk_sys);
		// idle levels out of reset
		check_val("tx_line", 32'(tx_line), 32'h1);
		check_val("tx_busy", 32'(tx_busy), 32'h0);
		check_val("frame_done", 32'(frame_done), 32'h0);
		check_val("frame_valid", 32'(frame_valid), 32'h0);
		check_val("frame_err", 32'(frame_err), 32'h0);
		check_val("fire_tx", 32'(UUT.fire_tx), 32'h0);
		check_val("done_tx", 32'(UUT.done_tx), 32'h0);
		check_val("byte_valid", 32'(UUT.byte_valid), 32'h0);
		check_val("stop_err", 32'(UUT.stop_err), 32'h0);
		for (int i = 0; i < ROWS; i++)
			run_row(i);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* project.f */
ctrl_link_pkg.sv
sim_ctrl_phy.sv
sim_ctrl_rx_phy.sv
ctrl_frame_tx.sv
ctrl_frame_rx.sv
ctrl_link_top.sv
ctrl_link_asserts.sv
tb_ctrl_link.sv

/* Makefile */
TOP     := tb_ctrl_link
OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
